//--- design/buttonHitTest.sv
// Button hit test.
// Two-stage pipelined check of the pointer against the upper and lower button rectangles.

`default_nettype none

module buttonHitTest #(
    parameter gameScreensPkg::coord_t buttonX      = 12'd0,
    parameter gameScreensPkg::coord_t upperButtonY = 12'd0,
    parameter gameScreensPkg::coord_t lowerButtonY = 12'd0,
    parameter gameScreensPkg::coord_t buttonWidth  = 12'd1,
    parameter gameScreensPkg::coord_t buttonHeight = 12'd1
) (
    input  logic                        clk,
    input  logic                        rst,
    input  gameScreensPkg::coord_t      xpos,
    input  gameScreensPkg::coord_t      ypos,
    output gameScreensPkg::buttonHits_t hits
);

    import gameScreensPkg::*;

    // Far edges, inclusive.
    localparam coord_t buttonRight = buttonX + buttonWidth;
    localparam coord_t upperBottom = upperButtonY + buttonHeight;
    localparam coord_t lowerBottom = lowerButtonY + buttonHeight;

    logic inColumn;
    logic inUpperRows;
    logic inLowerRows;

    logic inColumnNext;
    logic inUpperRowsNext;
    logic inLowerRowsNext;

    ////////////////////////////////
    // Stage one
    ////////////////////////////////

    always_comb begin
        inColumnNext    = (xpos >= buttonX) && (xpos <= buttonRight);
        inUpperRowsNext = (ypos >= upperButtonY) && (ypos <= upperBottom);
        inLowerRowsNext = (ypos >= lowerButtonY) && (ypos <= lowerBottom);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            inColumn    <= 1'b0;
            inUpperRows <= 1'b0;
            inLowerRows <= 1'b0;
        end else begin
            inColumn    <= inColumnNext;
            inUpperRows <= inUpperRowsNext;
            inLowerRows <= inLowerRowsNext;
        end
    end

    ////////////////////////////////
    // Stage two
    ////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            hits <= '0;
        end else begin
            hits.upperHit <= inColumn && inUpperRows;
            hits.lowerHit <= inColumn && inLowerRows;  // Same column for both buttons.
        end
    end

endmodule

`default_nettype wire

//--- design/gameScreens.sv
// Game screen flow controller.
// Hit test and button synchronizer run side by side and feed the screen state machine.

`default_nettype none

module gameScreens #(
    parameter gameScreensPkg::coord_t buttonX      = gameScreensPkg::defaultButtonX,
    parameter gameScreensPkg::coord_t upperButtonY = gameScreensPkg::defaultUpperButtonY,
    parameter gameScreensPkg::coord_t lowerButtonY = gameScreensPkg::defaultLowerButtonY,
    parameter gameScreensPkg::coord_t buttonWidth  = gameScreensPkg::defaultButtonWidth,
    parameter gameScreensPkg::coord_t buttonHeight = gameScreensPkg::defaultButtonHeight
) (
    input  logic                    clk,
    input  logic                    rst,
    input  gameScreensPkg::coord_t  xpos,
    input  gameScreensPkg::coord_t  ypos,
    input  logic                    mouseLeft,
    input  logic                    mouseRight,
    output gameScreensPkg::screen_t screen
);

    import gameScreensPkg::*;

    buttonHits_t   hits;     // Two cycles behind xpos and ypos.
    mouseButtons_t buttons;  // Two cycles behind the mouse levels.

    buttonHitTest #(
        .buttonX      (buttonX),
        .upperButtonY (upperButtonY),
        .lowerButtonY (lowerButtonY),
        .buttonWidth  (buttonWidth),
        .buttonHeight (buttonHeight)
    ) i_buttonHitTest (
        .clk  (clk),
        .rst  (rst),
        .xpos (xpos),
        .ypos (ypos),
        .hits (hits)
    );

    mouseButtonSync i_mouseButtonSync (
        .clk        (clk),
        .rst        (rst),
        .mouseLeft  (mouseLeft),
        .mouseRight (mouseRight),
        .buttons    (buttons)
    );

    screenStateMachine i_screenStateMachine (
        .clk     (clk),
        .rst     (rst),
        .hits    (hits),
        .buttons (buttons),
        .screen  (screen)
    );

endmodule

`default_nettype wire

//--- design/gameScreensPkg.sv
// Game screen flow package.
// Coordinate type, screen codes, button structs and the default button geometry.

`default_nettype none

package gameScreensPkg;

    ////////////////////////////////
    // Types
    ////////////////////////////////

    // Pixel coordinate on the VGA screen.
    typedef logic [11:0] coord_t;

    // One-hot screen codes.
    typedef enum logic [3:0] {
        startScreen = 4'b0001,
        gameScreen  = 4'b0010,
        endScreen   = 4'b0100,
        releaseWait = 4'b1000  // Waits for left release after leaving the end screen.
    } screen_t;

    // Mouse button levels.
    typedef struct packed {
        logic left;
        logic right;
    } mouseButtons_t;

    // Pointer over the upper or lower on-screen button.
    typedef struct packed {
        logic upperHit;
        logic lowerHit;
    } buttonHits_t;

    ////////////////////////////////
    // Default button geometry
    ////////////////////////////////

    // Both buttons share one column, centred on an 800x600 screen.
    localparam coord_t defaultButtonX      = 12'd300;
    localparam coord_t defaultUpperButtonY = 12'd200;
    localparam coord_t defaultLowerButtonY = 12'd350;

    // Shared size, added to the edge for the far bound.
    localparam coord_t defaultButtonWidth  = 12'd200;
    localparam coord_t defaultButtonHeight = 12'd80;

endpackage

`default_nettype wire

//--- design/mouseButtonSync.sv
// Mouse button synchronizer.
// Two flip-flop stages bring the left and right button levels into the clk domain.

`default_nettype none

module mouseButtonSync (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          mouseLeft,
    input  logic                          mouseRight,
    output gameScreensPkg::mouseButtons_t buttons
);

    import gameScreensPkg::*;

    mouseButtons_t rawButtons;
    mouseButtons_t metaStage;  // First flop, may go metastable.

    always_comb begin
        rawButtons.left  = mouseLeft;
        rawButtons.right = mouseRight;
    end

    ////////////////////////////////
    // Synchronizer chain
    ////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            metaStage <= '0;
        end else begin
            metaStage <= rawButtons;
        end
    end

    // Second flop gives the same latency as the hit test.
    always_ff @(posedge clk) begin
        if (rst) begin
            buttons <= '0;
        end else begin
            buttons <= metaStage;
        end
    end

endmodule

`default_nettype wire

//--- design/screenStateMachine.sv
// Screen state machine.
// Picks the one-hot game screen from the button hits and the synchronized mouse buttons.

`default_nettype none

module screenStateMachine (
    input  logic                          clk,
    input  logic                          rst,
    input  gameScreensPkg::buttonHits_t   hits,
    input  gameScreensPkg::mouseButtons_t buttons,
    output gameScreensPkg::screen_t       screen
);

    import gameScreensPkg::*;

    screen_t nextScreen;

    logic anyHit;
    logic pressUpper;
    logic pressLower;

    ////////////////////////////////
    // Press qualifiers
    ////////////////////////////////

    always_comb begin
        anyHit     = hits.upperHit || hits.lowerHit;
        pressUpper = buttons.left && hits.upperHit;
        pressLower = buttons.left && hits.lowerHit;
    end

    ////////////////////////////////
    // Next state
    ////////////////////////////////

    always_comb begin
        nextScreen = screen;  // Hold by default.

        case (screen)
            startScreen: begin
                if (buttons.left && anyHit) begin
                    nextScreen = gameScreen;
                end
            end

            gameScreen: begin
                // Only the right button ends the game.
                if (buttons.right) begin
                    nextScreen = endScreen;
                end
            end

            endScreen: begin
                if (pressUpper) begin
                    nextScreen = releaseWait;
                end else if (pressLower) begin
                    nextScreen = gameScreen;  // Restart.
                end
            end

            releaseWait: begin
                // Keeps the same press from starting a new game.
                if (!buttons.left) begin
                    nextScreen = startScreen;
                end
            end

            default: begin
                nextScreen = screen;
            end
        endcase
    end

    ////////////////////////////////
    // State register
    ////////////////////////////////

    // The register drives the output directly.
    always_ff @(posedge clk) begin
        if (rst) begin
            screen <= startScreen;
        end else begin
            screen <= nextScreen;
        end
    end

endmodule

`default_nettype wire

//--- gameScreens.f
design/gameScreensPkg.sv
design/buttonHitTest.sv
design/mouseButtonSync.sv
design/screenStateMachine.sv
design/gameScreens.sv
test/gameScreens_assertions.sv
test/gameScreensTb.sv

//--- test/gameScreensTb.sv
// Game screen flow testbench.
// Directed and LFSR-driven presses, checked against the screen flow rules.

`default_nettype none

module gameScreensTb;

    timeunit 1ns;
    timeprecision 1ps;

    import gameScreensPkg::*;

    localparam int stepCount  = 66;  // Driven steps over all tests.
    localparam int stepCycles = 5;

    logic    clk;
    logic    rst;
    coord_t  xpos;
    coord_t  ypos;
    logic    mouseLeft;
    logic    mouseRight;
    screen_t screen;

    logic [15:0] lfsrState = 16'd73;
    int          testErrors = 0;
    int          passCount = 0;
    int          failCount = 0;
    int          assertFailures;
    screen_t     modelScreen;

    gameScreens i_gameScreens (
        .clk        (clk),
        .rst        (rst),
        .xpos       (xpos),
        .ypos       (ypos),
        .mouseLeft  (mouseLeft),
        .mouseRight (mouseRight),
        .screen     (screen)
    );

    always #10 clk = ~clk;

    initial begin
        #(2 * stepCount * stepCycles * 20 + 2000);
        $display("Timeout: the tests did not finish in the expected time");
        $display("Simulation failed");
        $finish;
    end

    ////////////////////////////////
    // Reference model
    ////////////////////////////////

    // Galois LFSR, one step per bit taken.
    function automatic logic [15:0] nextBits(input int count);
        logic [15:0] value;
        logic        outBit;
        value = '0;
        for (int i = 0; i < count; i++) begin
            outBit    = lfsrState[0];
            lfsrState = lfsrState >> 1;
            if (outBit) lfsrState = lfsrState ^ 16'hB400;
            value = {value[14:0], outBit};
        end
        return value;
    endfunction

    function automatic logic inColumn(input coord_t x);
        return (x >= defaultButtonX) && (x <= defaultButtonX + defaultButtonWidth);
    endfunction

    function automatic logic overUpper(input coord_t x, input coord_t y);
        return inColumn(x) && (y >= defaultUpperButtonY)
            && (y <= defaultUpperButtonY + defaultButtonHeight);
    endfunction

    function automatic logic overLower(input coord_t x, input coord_t y);
        return inColumn(x) && (y >= defaultLowerButtonY)
            && (y <= defaultLowerButtonY + defaultButtonHeight);
    endfunction

    function automatic screen_t predictScreen(input screen_t cur, input logic left,
                                              input logic right, input coord_t x,
                                              input coord_t y);
        case (cur)
            startScreen: return (left && (overUpper(x, y) || overLower(x, y))) ? gameScreen : cur;
            gameScreen:  return right ? endScreen : cur;
            endScreen: begin
                if (left && overUpper(x, y)) return releaseWait;
                if (left && overLower(x, y)) return gameScreen;
                return cur;
            end
            default:     return left ? cur : startScreen;
        endcase
    endfunction

    // Two edges see the new inputs before the check.
    function automatic screen_t settledScreen(input screen_t cur, input logic left,
                                              input logic right, input coord_t x,
                                              input coord_t y);
        return predictScreen(predictScreen(cur, left, right, x, y), left, right, x, y);
    endfunction

    ////////////////////////////////
    // Drive and check
    ////////////////////////////////

    task automatic checkScreen(input screen_t expected);
        assert (screen === expected)
        else begin
            $display("FAIL time=%0t screen expected=%b actual=%b", $time, expected, screen);
            testErrors++;
        end
    endtask

    task automatic driveAndCheck(input coord_t x, input coord_t y, input logic left,
                                 input logic right, input screen_t expected);
        @(posedge clk);
        #2;
        xpos       = x;
        ypos       = y;
        mouseLeft  = left;
        mouseRight = right;
        repeat (4) @(posedge clk);
        #1;
        checkScreen(expected);
    endtask

    task automatic finishTest(input string name);
        if (testErrors == 0) begin
            $display("%s: passed", name);
            passCount++;
        end else begin
            $display("%s: %0d errors", name, testErrors);
            failCount++;
        end
        testErrors = 0;
    endtask

    task automatic returnToStart();  // From gameScreen.
        driveAndCheck(12'd0, 12'd0, 1'b0, 1'b1, endScreen);
        driveAndCheck(12'd0, 12'd0, 1'b0, 1'b0, endScreen);
        driveAndCheck(defaultButtonX, defaultUpperButtonY, 1'b1, 1'b0, releaseWait);
        driveAndCheck(defaultButtonX, defaultUpperButtonY, 1'b0, 1'b0, startScreen);
    endtask

    ////////////////////////////////
    // Tests
    ////////////////////////////////

    task automatic testResetAndMisses();
        coord_t midX;
        coord_t midY;
        midX = defaultButtonX + 12'd10;
        midY = defaultUpperButtonY + 12'd10;
        checkScreen(startScreen);
        driveAndCheck(defaultButtonX - 12'd1, midY, 1'b1, 1'b0, startScreen);
        driveAndCheck(defaultButtonX + defaultButtonWidth + 12'd1, midY, 1'b1, 1'b0, startScreen);
        driveAndCheck(midX, defaultUpperButtonY - 12'd1, 1'b1, 1'b0, startScreen);
        driveAndCheck(midX, defaultUpperButtonY + defaultButtonHeight + 12'd1, 1'b1, 1'b0,
                      startScreen);
        driveAndCheck(midX, defaultLowerButtonY - 12'd1, 1'b1, 1'b0, startScreen);
        driveAndCheck(midX, defaultLowerButtonY + defaultButtonHeight + 12'd1, 1'b1, 1'b0,
                      startScreen);
        finishTest("reset and misses");
    endtask

    task automatic testEnterGame();
        coord_t x;
        coord_t y;
        driveAndCheck(defaultButtonX, defaultUpperButtonY, 1'b1, 1'b0, gameScreen);
        returnToStart();
        driveAndCheck(defaultButtonX + defaultButtonWidth,
                      defaultLowerButtonY + defaultButtonHeight, 1'b1, 1'b0, gameScreen);
        returnToStart();
        x = defaultButtonX + coord_t'(nextBits(7));
        y = (nextBits(1) ? defaultUpperButtonY : defaultLowerButtonY) + coord_t'(nextBits(6));
        driveAndCheck(x, y, 1'b1, 1'b0, gameScreen);
        finishTest("enter game");
    endtask

    task automatic testGameScreen();
        driveAndCheck(defaultButtonX, defaultUpperButtonY, 1'b1, 1'b0, gameScreen);
        driveAndCheck(defaultButtonX + 12'd50, defaultLowerButtonY, 1'b1, 1'b0, gameScreen);
        driveAndCheck(12'd5, 12'd5, 1'b1, 1'b0, gameScreen);
        driveAndCheck(12'd5, 12'd5, 1'b0, 1'b1, endScreen);
        finishTest("game screen");
    endtask

    task automatic testRestart();
        driveAndCheck(defaultButtonX + 12'd20, defaultLowerButtonY + 12'd20, 1'b1, 1'b0,
                      gameScreen);
        driveAndCheck(defaultButtonX + 12'd20, defaultLowerButtonY + 12'd20, 1'b0, 1'b1,
                      endScreen);
        finishTest("restart");
    endtask

    task automatic testReleaseWait();
        driveAndCheck(defaultButtonX + 12'd40, defaultUpperButtonY + 12'd40, 1'b1, 1'b0,
                      releaseWait);
        driveAndCheck(12'd700, 12'd500, 1'b1, 1'b0, releaseWait);  // Held while moving.
        driveAndCheck(12'd700, 12'd500, 1'b0, 1'b0, startScreen);
        finishTest("release wait");
    endtask

    task automatic testRandomPresses();
        coord_t  x;
        coord_t  y;
        logic    useLeft;
        screen_t expected;
        modelScreen = startScreen;
        repeat (20) begin
            x        = 12'd250 + coord_t'(nextBits(8));
            y        = 12'd150 + coord_t'(nextBits(8));
            useLeft  = nextBits(1);
            expected = settledScreen(modelScreen, useLeft, !useLeft, x, y);
            driveAndCheck(x, y, useLeft, !useLeft, expected);
            modelScreen = expected;
            expected    = settledScreen(modelScreen, 1'b0, 1'b0, x, y);
            driveAndCheck(x, y, 1'b0, 1'b0, expected);
            modelScreen = expected;
        end
        finishTest("random presses");
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        xpos       = '0;
        ypos       = '0;
        mouseLeft  = 1'b0;
        mouseRight = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;

        testResetAndMisses();
        testEnterGame();
        testGameScreen();
        testRestart();
        testReleaseWait();
        testRandomPresses();

        assertFailures = i_gameScreens.i_screenStateMachine.i_assertions.failureCount;
        $display("Tests: %0d passed, %0d failed, %0d assertion failures", passCount,
                 failCount, assertFailures);
        if (failCount == 0 && assertFailures == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/gameScreens_assertions.sv
// Screen state machine assertions.
// Bound to the state machine, checks the one-hot code and the legal screen changes.

`default_nettype none

module gameScreens_assertions (
    input logic                    clk,
    input logic                    rst,
    input gameScreensPkg::screen_t screen
);

    timeunit 1ns;
    timeprecision 1ps;

    import gameScreensPkg::*;

    int failureCount = 0;  // Read by the testbench at the end of the run.

    ////////////////////////////////
    // Properties
    ////////////////////////////////

    screenOneHot: assert property (@(posedge clk) disable iff (rst) $onehot(screen))
        else begin
            $error("screen is not one-hot: %b", screen);
            failureCount++;
        end

    // Only the end screen leads into the release wait.
    releaseWaitFromEnd: assert property (@(posedge clk) disable iff (rst)
        (screen != endScreen && screen != releaseWait) |=> (screen != releaseWait))
        else begin
            $error("releaseWait entered from a screen other than endScreen");
            failureCount++;
        end

    gameNotToStart: assert property (@(posedge clk) disable iff (rst)
        (screen == gameScreen) |=> (screen != startScreen))
        else begin
            $error("gameScreen went directly to startScreen");
            failureCount++;
        end

endmodule

bind screenStateMachine gameScreens_assertions i_assertions (
    .clk    (clk),
    .rst    (rst),
    .screen (screen)
);

`default_nettype wire
